/* design/tcdm_pkg.sv */
`default_nettype none

package tcdm_pkg;

  // channel count; channel i always maps onto bank i
  localparam int NCHAN   = 2;

  // word address inside one bank, 64 words deep
  localparam int ADDR_W  = 6;

  localparam int DATA_W  = 32;            // data word width
  localparam int BE_W    = DATA_W / 8;    // one enable per byte lane

  // stall limit and stall counter width
  localparam int STALL_W = 8;

  typedef logic [DATA_W-1:0]  word_t;     // one data word
  typedef logic [ADDR_W-1:0]  addr_t;     // word address within a bank
  typedef logic [BE_W-1:0]    be_t;       // byte-enable vector
  typedef logic [STALL_W-1:0] stall_t;    // stall count / limit

  // side that owns a channel in a given cycle
  // high is the default priority side, swap_prio_i exchanges the roles
  typedef enum logic {
    SIDE_HIGH = 1'b0,
    SIDE_LOW  = 1'b1
  } side_e;

endpackage

`default_nettype wire

/* design/tcdm_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module tcdm_arbiter (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,
  input  logic                                    swap_prio_i,   // low side takes priority
  input  tcdm_pkg::stall_t                        stall_limit_i, // 0 disables the override

  // high side requests
  input  logic            [tcdm_pkg::NCHAN-1:0]   high_req,
  input  tcdm_pkg::addr_t [tcdm_pkg::NCHAN-1:0]   high_addr,
  input  logic            [tcdm_pkg::NCHAN-1:0]   high_wen,      // 1 = read
  input  tcdm_pkg::be_t   [tcdm_pkg::NCHAN-1:0]   high_be,
  input  tcdm_pkg::word_t [tcdm_pkg::NCHAN-1:0]   high_wdata,
  output logic            [tcdm_pkg::NCHAN-1:0]   high_gnt,

  // low side requests
  input  logic            [tcdm_pkg::NCHAN-1:0]   low_req,
  input  tcdm_pkg::addr_t [tcdm_pkg::NCHAN-1:0]   low_addr,
  input  logic            [tcdm_pkg::NCHAN-1:0]   low_wen,
  input  tcdm_pkg::be_t   [tcdm_pkg::NCHAN-1:0]   low_be,
  input  tcdm_pkg::word_t [tcdm_pkg::NCHAN-1:0]   low_wdata,
  output logic            [tcdm_pkg::NCHAN-1:0]   low_gnt,

  // towards the banks
  output logic            [tcdm_pkg::NCHAN-1:0]   bank_req,
  output tcdm_pkg::addr_t [tcdm_pkg::NCHAN-1:0]   bank_addr,
  output logic            [tcdm_pkg::NCHAN-1:0]   bank_wen,
  output tcdm_pkg::be_t   [tcdm_pkg::NCHAN-1:0]   bank_be,
  output tcdm_pkg::word_t [tcdm_pkg::NCHAN-1:0]   bank_wdata,
  output tcdm_pkg::side_e [tcdm_pkg::NCHAN-1:0]   pass_side      // to the response router
);

  import tcdm_pkg::*;

  logic [NCHAN-1:0] prio_req;     // requests of whichever side holds priority now
  logic [NCHAN-1:0] np_req;       // requests of the other side
  logic             any_prio;     // global priority request, after stall override
  logic             any_np;       // global non-priority request
  logic             stall_hit;    // starved side has waited long enough
  logic [NCHAN-1:0] prio_pass;    // priority side wins channel i
  logic [NCHAN-1:0] high_sel;     // high side owns channel i
  stall_t           stall_cnt_q;

  // swap the roles of the two sides
  assign prio_req = swap_prio_i ? low_req  : high_req;
  assign np_req   = swap_prio_i ? high_req : low_req;

  // a zero limit turns the starvation override off
  assign stall_hit = (stall_limit_i != '0) && (stall_cnt_q >= stall_limit_i);

  assign any_prio = (|prio_req) & ~stall_hit;  // let the starved side through once
  assign any_np   = |np_req;

  // priority side passes only on channels it actually requests
  assign prio_pass = {NCHAN{any_prio}} & prio_req;

  // back to the physical side: with swap set, priority means low
  assign high_sel = prio_pass ^ {NCHAN{swap_prio_i}};

  // counts cycles where both sides want the memory and priority keeps winning
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      stall_cnt_q <= '0;
    else if (clear_i)
      stall_cnt_q <= '0;
    else if (any_prio && any_np)
      stall_cnt_q <= stall_cnt_q + stall_t'(1);
    else
      stall_cnt_q <= '0;   // any gap restarts the count
  end

  // per-channel mux and grant
  always_comb
  begin
    for (int i = 0; i < NCHAN; i++)
    begin
      if (high_sel[i])
      begin
        bank_req[i]   = high_req[i];
        bank_addr[i]  = high_addr[i];
        bank_wen[i]   = high_wen[i];
        bank_be[i]    = high_be[i];
        bank_wdata[i] = high_wdata[i];
        pass_side[i]  = SIDE_HIGH;
        high_gnt[i]   = high_req[i];   // banks never refuse
        low_gnt[i]    = 1'b0;
      end
      else
      begin
        bank_req[i]   = low_req[i];
        bank_addr[i]  = low_addr[i];
        bank_wen[i]   = low_wen[i];
        bank_be[i]    = low_be[i];
        bank_wdata[i] = low_wdata[i];
        pass_side[i]  = SIDE_LOW;
        high_gnt[i]   = 1'b0;          // loser holds req and payload
        low_gnt[i]    = low_req[i];
      end
    end
  end

endmodule

`default_nettype wire

/* design/tcdm_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module tcdm_bank (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req,     // always accepted, no grant back
  input  tcdm_pkg::addr_t  addr,    // word address
  input  logic             wen,     // 1 = read, 0 = write
  input  tcdm_pkg::be_t    be,      // byte enables, writes only
  input  tcdm_pkg::word_t  wdata,
  output tcdm_pkg::word_t  rdata    // valid the cycle after a read
);

  import tcdm_pkg::*;

  localparam int DEPTH = 2 ** ADDR_W;

  word_t mem [DEPTH];   // storage array
  word_t rdata_q;       // registered read port
  logic  do_write;
  logic  do_read;

  assign do_write = req & ~wen;
  assign do_read  = req &  wen;

  // byte-lane writes, applied in the request cycle
  always_ff @(posedge clk_i)
  begin
    if (do_write)
    begin
      for (int b = 0; b < BE_W; b++)
      begin
        if (be[b])
          mem[addr][8*b +: 8] <= wdata[8*b +: 8];   // untouched lanes keep old data
      end
    end
  end

  // read register, holds its value until the next read
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rdata_q <= '0;
    else if (do_read)
      rdata_q <= mem[addr];
  end

  assign rdata = rdata_q;

endmodule

`default_nettype wire

/* design/tcdm_resp_router.sv */
`timescale 1ns/100ps
`default_nettype none

module tcdm_resp_router (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,   // drops pending pulses

  // from the arbiter, sampled in the transfer cycle
  input  logic            [tcdm_pkg::NCHAN-1:0]   bank_req,
  input  tcdm_pkg::side_e [tcdm_pkg::NCHAN-1:0]   pass_side,

  // from the banks, one cycle after the transfer
  input  tcdm_pkg::word_t [tcdm_pkg::NCHAN-1:0]   bank_rdata,

  // responses, one set per side
  output logic            [tcdm_pkg::NCHAN-1:0]   high_r_valid,
  output logic            [tcdm_pkg::NCHAN-1:0]   low_r_valid,
  output tcdm_pkg::word_t [tcdm_pkg::NCHAN-1:0]   high_r_rdata,
  output tcdm_pkg::word_t [tcdm_pkg::NCHAN-1:0]   low_r_rdata
);

  import tcdm_pkg::*;

  logic  [NCHAN-1:0] pend_q;   // a transfer happened on channel i last cycle
  side_e [NCHAN-1:0] side_q;   // who owned channel i last cycle

  // every transfer, read or write, gets exactly one response pulse
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pend_q <= '0;
      side_q <= {NCHAN{SIDE_HIGH}};
    end
    else if (clear_i)
    begin
      pend_q <= '0;
      side_q <= side_q;
    end
    else
    begin
      pend_q <= bank_req;
      side_q <= pass_side;
    end
  end

  // steer the pulse to the recorded owner
  always_comb
  begin
    for (int i = 0; i < NCHAN; i++)
    begin
      high_r_valid[i] = pend_q[i] & (side_q[i] == SIDE_HIGH);
      low_r_valid[i]  = pend_q[i] & (side_q[i] == SIDE_LOW);
    end
  end

  // data goes to both sides; only the one with r_valid cares
  assign high_r_rdata = bank_rdata;
  assign low_r_rdata  = bank_rdata;

endmodule

`default_nettype wire

/* design/tcdm_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tcdm_subsystem (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,
  input  logic                                    swap_prio_i,
  input  tcdm_pkg::stall_t                        stall_limit_i,

  // high side
  input  logic            [tcdm_pkg::NCHAN-1:0]   high_req,
  input  tcdm_pkg::addr_t [tcdm_pkg::NCHAN-1:0]   high_addr,
  input  logic            [tcdm_pkg::NCHAN-1:0]   high_wen,
  input  tcdm_pkg::be_t   [tcdm_pkg::NCHAN-1:0]   high_be,
  input  tcdm_pkg::word_t [tcdm_pkg::NCHAN-1:0]   high_wdata,
  output logic            [tcdm_pkg::NCHAN-1:0]   high_gnt,
  output logic            [tcdm_pkg::NCHAN-1:0]   high_r_valid,
  output tcdm_pkg::word_t [tcdm_pkg::NCHAN-1:0]   high_r_rdata,

  // low side
  input  logic            [tcdm_pkg::NCHAN-1:0]   low_req,
  input  tcdm_pkg::addr_t [tcdm_pkg::NCHAN-1:0]   low_addr,
  input  logic            [tcdm_pkg::NCHAN-1:0]   low_wen,
  input  tcdm_pkg::be_t   [tcdm_pkg::NCHAN-1:0]   low_be,
  input  tcdm_pkg::word_t [tcdm_pkg::NCHAN-1:0]   low_wdata,
  output logic            [tcdm_pkg::NCHAN-1:0]   low_gnt,
  output logic            [tcdm_pkg::NCHAN-1:0]   low_r_valid,
  output tcdm_pkg::word_t [tcdm_pkg::NCHAN-1:0]   low_r_rdata
);

  import tcdm_pkg::*;

  // arbiter to banks
  logic  [NCHAN-1:0] bank_req;
  addr_t [NCHAN-1:0] bank_addr;
  logic  [NCHAN-1:0] bank_wen;
  be_t   [NCHAN-1:0] bank_be;
  word_t [NCHAN-1:0] bank_wdata;
  side_e [NCHAN-1:0] pass_side;    // arbiter to router
  word_t [NCHAN-1:0] bank_rdata;   // banks to router

  tcdm_arbiter u_arbiter (
    .clk_i, .rst_ni, .clear_i, .swap_prio_i, .stall_limit_i,
    .high_req, .high_addr, .high_wen, .high_be, .high_wdata, .high_gnt,
    .low_req, .low_addr, .low_wen, .low_be, .low_wdata, .low_gnt,
    .bank_req, .bank_addr, .bank_wen, .bank_be, .bank_wdata, .pass_side
  );

  // one bank per channel and no address decoding across banks
  for (genvar i = 0; i < NCHAN; i++)
  begin : gen_bank
    tcdm_bank u_bank (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req    (bank_req[i]),
      .addr   (bank_addr[i]),
      .wen    (bank_wen[i]),
      .be     (bank_be[i]),
      .wdata  (bank_wdata[i]),
      .rdata  (bank_rdata[i])
    );
  end

  tcdm_resp_router u_router (
    .clk_i, .rst_ni, .clear_i,
    .bank_req, .pass_side, .bank_rdata,
    .high_r_valid, .low_r_valid, .high_r_rdata, .low_r_rdata
  );

endmodule

`default_nettype wire

/* verification/tb_tcdm_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_tcdm_subsystem;

  import tcdm_pkg::*;

  localparam int    HALF_PERIOD = 20;           // 40 ns clock
  localparam int    RST_CYCLES  = 2;
  localparam int    NFIELDS     = 20;           // tokens per golden line
  localparam int    MAX_LINES   = 64;
  localparam string GOLDEN_FILE = "verification/tcdm_golden.txt";

  // column positions inside one golden line
  localparam int F_ID     = 0;
  localparam int F_CLR    = 1;
  localparam int F_SWP    = 2;
  localparam int F_LIM    = 3;
  localparam int F_HREQ   = 4;
  localparam int F_HWEN   = 5;
  localparam int F_HADDR  = 6;
  localparam int F_HBE    = 7;
  localparam int F_HWDATA = 8;
  localparam int F_LREQ   = 9;
  localparam int F_LWEN   = 10;
  localparam int F_LADDR  = 11;
  localparam int F_LBE    = 12;
  localparam int F_LWDATA = 13;
  localparam int F_EHG    = 14;
  localparam int F_ELG    = 15;
  localparam int F_EHV    = 16;
  localparam int F_ELV    = 17;
  localparam int F_ERD0   = 18;

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             clear_i;
  logic             swap_prio_i;
  stall_t           stall_limit_i;

  logic [NCHAN-1:0] high_req;
  addr_t [NCHAN-1:0] high_addr;
  logic [NCHAN-1:0] high_wen;
  be_t  [NCHAN-1:0] high_be;
  word_t [NCHAN-1:0] high_wdata;
  logic [NCHAN-1:0] high_gnt;
  logic [NCHAN-1:0] high_r_valid;
  word_t [NCHAN-1:0] high_r_rdata;

  logic [NCHAN-1:0] low_req;
  addr_t [NCHAN-1:0] low_addr;
  logic [NCHAN-1:0] low_wen;
  be_t  [NCHAN-1:0] low_be;
  word_t [NCHAN-1:0] low_wdata;
  logic [NCHAN-1:0] low_gnt;
  logic [NCHAN-1:0] low_r_valid;
  word_t [NCHAN-1:0] low_r_rdata;

  logic [31:0] gold_mem [MAX_LINES*NFIELDS];   // NFIELDS words per golden line
  int          n_lines      = 0;
  int          cycle_cnt    = 0;
  int          cycle_limit  = 0;
  int          gnt_errors   = 0;
  int          valid_errors = 0;
  int          data_errors  = 0;
  int          other_errors = 0;

  tcdm_subsystem u_dut (
    .clk_i, .rst_ni, .clear_i, .swap_prio_i, .stall_limit_i,
    .high_req, .high_addr, .high_wen, .high_be, .high_wdata,
    .high_gnt, .high_r_valid, .high_r_rdata,
    .low_req, .low_addr, .low_wen, .low_be, .low_wdata,
    .low_gnt, .low_r_valid, .low_r_rdata
  );

  always #HALF_PERIOD clk_i = ~clk_i;

  function automatic string test_name(input int id);
    case (id)
      1:       return "single_side";
      2:       return "fixed_priority";
      3:       return "swap_priority";
      4:       return "stall_limit";
      5:       return "byte_enable_clear";
      default: return "unknown";
    endcase
  endfunction

  // counts whitespace separated tokens up to a // comment
  function automatic int count_tokens(input string s);
    int  n      = 0;
    bit  in_tok = 1'b0;
    byte ch;
    for (int i = 0; i < s.len(); i++)
    begin
      ch = s[i];
      if (ch == "/" && i + 1 < s.len() && s[i+1] == "/")
        break;
      if (ch == " " || ch == "\t" || ch == "\n" || ch == "\r")
        in_tok = 1'b0;
      else if (!in_tok)
      begin
        n++;
        in_tok = 1'b1;
      end
    end
    return n;
  endfunction

  task automatic load_golden();
    int    fd;
    int    ntok;
    string line;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0)
    begin
      other_errors++;
      $display("cannot open the golden file %s", GOLDEN_FILE);
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      if ($fgets(line, fd) == 0)
        break;
      ntok = count_tokens(line);
      if (ntok == 0)
        continue;                               // blank or comment line
      if (ntok != NFIELDS)
      begin
        other_errors++;
        $display("golden line %0d has %0d fields instead of %0d",
                 n_lines + 1, ntok, NFIELDS);
      end
      n_lines++;
    end
    $fclose(fd);
    if (n_lines == 0)
    begin
      other_errors++;
      $display("the golden file holds no stimulus lines");
    end
    if (n_lines > MAX_LINES)
    begin
      other_errors++;
      $display("the golden file has %0d lines, more than the %0d allowed", n_lines, MAX_LINES);
    end
    if (other_errors == 0)
      $readmemh(GOLDEN_FILE, gold_mem);
    else
      n_lines = 0;                              // nothing trustworthy to run
  endtask

  task automatic init_inputs();
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    swap_prio_i   = 1'b0;
    stall_limit_i = '0;
    high_req      = '0;
    high_addr     = '0;
    high_wen      = '0;
    high_be       = '0;
    high_wdata    = '0;
    low_req       = '0;
    low_addr      = '0;
    low_wen       = '0;
    low_be        = '0;
    low_wdata     = '0;
  endtask

  // one payload per side for both channels while req and wen are per channel
  task automatic apply_line(input int k);
    int base;
    base          = k * NFIELDS;
    clear_i       = gold_mem[base+F_CLR][0];
    swap_prio_i   = gold_mem[base+F_SWP][0];
    stall_limit_i = stall_t'(gold_mem[base+F_LIM]);
    high_req      = gold_mem[base+F_HREQ][NCHAN-1:0];
    high_wen      = gold_mem[base+F_HWEN][NCHAN-1:0];
    low_req       = gold_mem[base+F_LREQ][NCHAN-1:0];
    low_wen       = gold_mem[base+F_LWEN][NCHAN-1:0];
    for (int c = 0; c < NCHAN; c++)
    begin
      high_addr[c]  = addr_t'(gold_mem[base+F_HADDR]);
      high_be[c]    = be_t'(gold_mem[base+F_HBE]);
      high_wdata[c] = gold_mem[base+F_HWDATA];
      low_addr[c]   = addr_t'(gold_mem[base+F_LADDR]);
      low_be[c]     = be_t'(gold_mem[base+F_LBE]);
      low_wdata[c]  = gold_mem[base+F_LWDATA];
    end
  endtask

  task automatic check_gnt(input string name, input logic [NCHAN-1:0] exp_v,
                           input logic [NCHAN-1:0] act_v);
    if (act_v !== exp_v)
    begin
      gnt_errors++;
      $display("Fail %s: expected %b, actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_valid(input string name, input logic [NCHAN-1:0] exp_v,
                             input logic [NCHAN-1:0] act_v);
    if (act_v !== exp_v)
    begin
      valid_errors++;
      $display("Fail %s: expected %b, actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_rdata(input string name, input word_t exp_v, input word_t act_v);
    if (act_v !== exp_v)
    begin
      data_errors++;
      $display("Fail %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_line(input int k);
    int               base;
    string            tag;
    logic [NCHAN-1:0] exp_hv;
    logic [NCHAN-1:0] exp_lv;
    base   = k * NFIELDS;
    tag    = $sformatf("%s line %0d", test_name(int'(gold_mem[base+F_ID])), k + 1);
    exp_hv = gold_mem[base+F_EHV][NCHAN-1:0];
    exp_lv = gold_mem[base+F_ELV][NCHAN-1:0];
    check_gnt($sformatf("%s high_gnt", tag), gold_mem[base+F_EHG][NCHAN-1:0], high_gnt);
    check_gnt($sformatf("%s low_gnt", tag), gold_mem[base+F_ELG][NCHAN-1:0], low_gnt);
    check_valid($sformatf("%s high_r_valid", tag), exp_hv, high_r_valid);
    check_valid($sformatf("%s low_r_valid", tag), exp_lv, low_r_valid);
    for (int c = 0; c < NCHAN; c++)
    begin
      if (exp_hv[c])                            // data only counts with a valid pulse
        check_rdata($sformatf("%s high_r_rdata[%0d]", tag, c),
                    gold_mem[base+F_ERD0+c], high_r_rdata[c]);
      if (exp_lv[c])
        check_rdata($sformatf("%s low_r_rdata[%0d]", tag, c),
                    gold_mem[base+F_ERD0+c], low_r_rdata[c]);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d grant, %0d valid, %0d data, %0d other",
             gnt_errors, valid_errors, data_errors, other_errors);
    if (gnt_errors + valid_errors + data_errors + other_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  endtask

  initial
  begin
    init_inputs();
    load_golden();
    cycle_limit = RST_CYCLES + n_lines + 20;
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int k = 0; k < n_lines; k++)
    begin
      @(negedge clk_i);
      apply_line(k);                            // drive mid cycle
      #(HALF_PERIOD - 2);                       // sample just ahead of the rising edge
      check_line(k);
    end
    finish_run();
  end

  // guard against a stuck run
  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
    begin
      other_errors++;
      $display("timeout after %0d cycles, the stimulus did not complete", cycle_cnt);
      finish_run();
    end
  end

endmodule

`default_nettype wire

/* verification/tcdm_golden.txt */
// id clr swp lim | high: req wen addr be wdata | low: req wen addr be wdata
// expected: high_gnt low_gnt high_r_valid low_r_valid rdata_ch0 rdata_ch1
// single side, low writes bank 0 then bank 1, reads both back
1 0 0 00 0 0 00 0 00000000 1 0 05 f 11110000 0 1 0 0 00000000 00000000
1 0 0 00 0 0 00 0 00000000 2 0 05 f 22220001 0 2 0 1 00000000 00000000
1 0 0 00 0 0 00 0 00000000 3 3 05 f 00000000 0 3 0 2 00000000 00000000
1 0 0 00 0 0 00 0 00000000 0 0 00 0 00000000 0 0 0 3 11110000 22220001
// fixed priority, then high on ch0 only while low uses ch1
2 0 0 00 1 0 0a f 33330000 1 0 0b f 44440000 1 0 0 0 00000000 00000000
2 0 0 00 0 0 00 0 00000000 1 0 0b f 44440000 0 1 1 0 11110000 00000000
2 0 0 00 1 1 0a f 00000000 2 2 05 f 00000000 1 2 0 1 11110000 00000000
2 0 0 00 0 0 00 0 00000000 1 1 0b f 00000000 0 1 1 2 33330000 22220001
2 0 0 00 0 0 00 0 00000000 0 0 00 0 00000000 0 0 0 1 44440000 00000000
// swapped priority, same pattern
3 0 1 00 1 0 0c f 55550000 1 0 0d f 66660000 0 1 0 0 00000000 00000000
3 0 1 00 1 0 0c f 55550000 0 0 00 0 00000000 1 0 0 1 44440000 00000000
3 0 1 00 2 2 05 f 00000000 1 1 0c f 00000000 2 1 1 0 44440000 00000000
3 0 1 00 0 0 00 0 00000000 0 0 00 0 00000000 0 0 2 1 55550000 22220001
// stall limit 3, low gets every fourth cycle
4 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 1 0 0 0 00000000 00000000
4 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 1 0 1 0 33330000 00000000
4 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 1 0 1 0 33330000 00000000
4 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 0 1 1 0 33330000 00000000
4 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 1 0 0 1 44440000 00000000
4 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 1 0 1 0 33330000 00000000
4 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 1 0 1 0 33330000 00000000
4 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 0 1 1 0 33330000 00000000
// stall limit 0, low starves
4 0 0 00 1 1 0a f 00000000 1 1 0b f 00000000 1 0 0 1 44440000 00000000
4 0 0 00 1 1 0a f 00000000 1 1 0b f 00000000 1 0 1 0 33330000 00000000
4 0 0 00 1 1 0a f 00000000 1 1 0b f 00000000 1 0 1 0 33330000 00000000
4 0 0 00 1 1 0a f 00000000 1 1 0b f 00000000 1 0 1 0 33330000 00000000
4 0 0 00 1 1 0a f 00000000 1 1 0b f 00000000 1 0 1 0 33330000 00000000
// clear restarts the stall count and drops the pending pulse
5 1 0 00 1 1 0a f 00000000 1 1 0b f 00000000 1 0 1 0 33330000 00000000
5 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 1 0 0 0 00000000 00000000
5 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 1 0 1 0 33330000 00000000
5 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 1 0 1 0 33330000 00000000
5 0 0 03 1 1 0a f 00000000 1 1 0b f 00000000 0 1 1 0 33330000 00000000
// partial write on bank 1, bytes 0 and 2, then readback
5 0 0 00 0 0 00 0 00000000 2 0 05 5 aabbccdd 0 2 0 1 44440000 00000000
5 0 0 00 0 0 00 0 00000000 2 2 05 f 00000000 0 2 0 2 00000000 22220001
5 0 0 00 0 0 00 0 00000000 0 0 00 0 00000000 0 0 0 2 00000000 22bb00dd

/* tb.f */
design/tcdm_pkg.sv
design/tcdm_arbiter.sv
design/tcdm_bank.sv
design/tcdm_resp_router.sv
design/tcdm_subsystem.sv
verification/tb_tcdm_subsystem.sv

/* Makefile */
# Verilator build and run of the TCDM subsystem testbench

RTL = design/tcdm_pkg.sv \
      design/tcdm_arbiter.sv \
      design/tcdm_bank.sv \
      design/tcdm_resp_router.sv \
      design/tcdm_subsystem.sv

.PHONY: all lint clean

# build, run, and pass only if the pass line shows up
all:
	verilator --binary --timing -j 0 --top-module tb_tcdm_subsystem \
		-f tb.f -Mdir obj_dir -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only -Wall --top-module tcdm_subsystem $(RTL)

clean:
	rm -rf obj_dir
